//--- hub_pkg.sv
// hub package with the hub address map, board entry geometry and broadcast timing constants
package hub_pkg;

    // address bits 15:12 that select the hub space
    localparam logic [3:0] addr_hub = 4'd1;

    // address bits 11:2 of the hub registers at 0x1800 to 0x1803
    localparam logic [9:0] hub_reg_block = 10'b1000000000;

    // quadlets that each board contributes to one broadcast entry
    localparam logic [8:0] num_quads = 9'd29;

    // each entry occupies a 32-quadlet slot, so the read skips this many quadlets
    // to reach the start of the next entry
    localparam logic [8:0] quad_offset = 9'd32 - num_quads;

    // board slots in hub memory, and slots in the ordered read index
    localparam int num_boards = 16;

    // timer value at which the lowest selected board starts its broadcast,
    // roughly 3 us at the system clock
    localparam logic [13:0] first_board_delay = 14'd150;

    // busy time of the broadcast transmitter for one packet
    localparam int bc_xmit_cycles = 40;

    // width of the transmitter busy counter
    localparam int bc_cnt_w = $clog2(bc_xmit_cycles + 1);

    // pattern stamped into bits 15:14 of an updated first quadlet
    localparam logic [1:0] upd_flag = 2'b10;

endpackage

//--- hub_mem.sv
// hub memory holding one 32-quadlet entry per board, with a write port and a registered read port
`timescale 1ns/10ps

module hub_mem (
    input  logic        sysclk,
    input  logic        wen,
    input  logic [8:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [8:0]  raddr,
    output logic [31:0] rdata
);

    // 16 boards times 32 quadlets, the board number is in address bits 8:5
    logic [31:0] mem [0:511];

    // the write port takes the data at the edge where wen is high
    always_ff @(posedge sysclk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // the read data shows up one cycle after the address
    always_ff @(posedge sysclk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- hub_reg.sv
// hub register block with the query register, board index, broadcast trigger and read mux
`timescale 1ns/10ps

module hub_reg
    import hub_pkg::*;
(
    input  logic        sysclk,
    input  logic        write_trig_reset,
    input  logic        reg_wen,
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic [15:0] reg_raddr,
    input  logic [3:0]  board_id,
    input  logic        fw_idle,
    input  logic [31:0] mem_rdata,
    input  logic [3:0]  read_board,
    input  logic        is_extra,
    output logic [31:0] reg_rdata,
    output logic [15:0] seq_num,
    output logic [15:0] board_mask,
    output logic        updated,
    output logic        write_trig,
    output logic        query_wen,
    output logic [63:0] read_index_flat,
    output logic        mem_wen,
    output logic [8:0]  mem_waddr,
    output logic [31:0] mem_wdata
);

    // the broadcast timer counts from the last query, or from the end of the index build
    logic [13:0] bc_timer;
    // timer value when the PC started reading hub memory at address 0
    logic [13:0] bc_read_start;
    // set once write_trig has gone out for the current query
    logic        write_trig_done;
    // index build state, the build runs while board_mask differs from last_mask
    logic [3:0]  cur_index;
    logic [3:0]  cur_board;
    logic [15:0] last_mask;
    // one bit per board, set when that board's entry arrives
    logic [15:0] board_updated;
    logic [15:0] board_mask_lower;
    logic        board_selected;
    logic        hub_reg_waddr;
    logic        hub_reg_raddr;
    logic        hub_mem_read0;
    logic        first_quad;
    logic [31:0] hub_rdata;

    // the hub registers sit at 0x1800 to 0x1803
    assign hub_reg_waddr = (reg_waddr[15:12] == addr_hub) && (reg_waddr[11:2] == hub_reg_block);
    assign hub_reg_raddr = (reg_raddr[15:12] == addr_hub) && (reg_raddr[11:2] == hub_reg_block);

    // only 0x1800 can be written, and a write there is the broadcast query
    assign query_wen = reg_wen && hub_reg_waddr && (reg_waddr[1:0] == 2'd0);

    // hub memory takes the low 512 quadlets of hub space
    assign mem_wen   = reg_wen && (reg_waddr[15:12] == addr_hub) && (reg_waddr[11:9] == 3'd0);
    assign mem_waddr = reg_waddr[8:0];

    // the first quadlet of an entry gets the update flag and the arrival time in bits 15:0
    assign mem_wdata = (reg_waddr[4:0] == 5'd0) ? {reg_wdata[31:16], upd_flag, bc_timer}
                                                : reg_wdata;

    // start of a sequential hub read, which marks the read-start time
    assign hub_mem_read0 = (reg_raddr[15:12] == addr_hub) && (reg_raddr[11:9] == 3'd0)
                           && (reg_raddr[8:0] == 9'd0);

    // boards with a lower number than this one, restricted to the ones in use
    assign board_mask_lower = ((16'd1 << board_id) - 16'd1) & board_mask;
    assign board_selected   = board_mask[board_id];

    // a mask of zero never counts as complete
    assign updated = (board_mask != 16'd0) && (board_updated == board_mask);

    always_ff @(posedge sysclk) begin
        if (write_trig_reset) begin
            seq_num         <= '0;
            board_mask      <= '0;
            last_mask       <= '0;
            cur_index       <= '0;
            cur_board       <= '0;
            read_index_flat <= '0;
            bc_timer        <= '0;
            bc_read_start   <= '0;
            board_updated   <= '0;
            write_trig      <= 1'b0;
            write_trig_done <= 1'b0;
        end else begin
            bc_timer <= bc_timer + 14'd1;
            if (query_wen) begin
                seq_num <= reg_wdata[31:16];
                // a zero mask would leave the index build without any board to find
                if (reg_wdata[15:0] != 16'd0) begin
                    board_mask <= reg_wdata[15:0];
                    cur_index  <= '0;
                    cur_board  <= '0;
                end
                bc_timer        <= '0;
                board_updated   <= '0;
                write_trig      <= 1'b0;
                write_trig_done <= 1'b0;
            end else if (board_mask != last_mask) begin
                // walk the boards round and round until all index slots are filled,
                // so the list of boards in use repeats across the 16 slots
                if (board_mask[cur_board]) begin
                    read_index_flat[63 - 4 * cur_index -: 4] <= cur_board;
                    cur_index <= cur_index + 4'd1;
                    if (cur_index == 4'(num_boards - 1)) begin
                        last_mask <= board_mask;
                        bc_timer  <= '0;
                    end
                end
                cur_board <= cur_board + 4'd1;
            end else if (board_selected && !write_trig_done) begin
                // boards broadcast in board-number order
                if (board_mask_lower == 16'd0) begin
                    // the lowest board goes after a fixed delay
                    if (bc_timer == first_board_delay) begin
                        write_trig      <= 1'b1;
                        write_trig_done <= 1'b1;
                    end
                end else if ((board_updated == board_mask_lower) && fw_idle) begin
                    // all lower boards have updated and the transmitter is free
                    write_trig      <= 1'b1;
                    write_trig_done <= 1'b1;
                end
            end
            if (hub_mem_read0 && !query_wen) begin
                bc_read_start <= bc_timer;
            end
            if (mem_wen) begin
                board_updated[reg_waddr[8:5]] <= 1'b1;
            end
        end
    end

    // in the sequential read space each entry starts at a multiple of num_quads
    assign first_quad = ((reg_raddr[8:0] % num_quads) == 9'd0);

    // a first quadlet reports the board's update bit in bit 15 with bit 14 clear,
    // the quadlet after the last entry carries the read-start time and the timer
    assign hub_rdata = is_extra   ? {2'b00, bc_read_start, 2'b00, bc_timer} :
                       first_quad ? {mem_rdata[31:16], board_updated[read_board], 1'b0,
                                     mem_rdata[13:0]} :
                                    mem_rdata;

    always_comb begin
        if (!hub_reg_raddr) begin
            reg_rdata = hub_rdata;
        end else begin
            case (reg_raddr[1:0])
                2'd0:    reg_rdata = {seq_num, board_mask};
                // index slots with slot 0 in the top nibble
                2'd1:    reg_rdata = read_index_flat[63:32];
                2'd2:    reg_rdata = read_index_flat[31:0];
                default: reg_rdata = {12'd0, board_id, board_mask_lower};
            endcase
        end
    end

endmodule

//--- hub_read_xlate.sv
// hub read translator that maps sequential read addresses onto 32-quadlet board entries
`timescale 1ns/10ps

module hub_read_xlate
    import hub_pkg::*;
(
    input  logic        sysclk,
    input  logic        write_trig_reset,
    input  logic [15:0] reg_raddr,
    input  logic        query_wen,
    input  logic [63:0] read_index_flat,
    output logic [8:0]  mem_raddr,
    output logic [3:0]  read_board,
    output logic        is_extra
);

    // running entry boundary in the sequential space, 29, 58, 87 and so on
    logic [8:0] mult_nq;
    // gap accumulated so far between sequential and memory addresses
    logic [8:0] offset;
    logic [8:0] raddr_offset;
    logic [3:0] slot;
    logic [3:0] first_board;
    logic       hub_mem_read;
    logic       at_boundary;

    assign hub_mem_read = (reg_raddr[15:12] == addr_hub) && (reg_raddr[11:9] == 3'd0);
    assign at_boundary  = (reg_raddr[8:0] == mult_nq);

    // the boundary re-arms on a query and on a read of address 0, so the hub can
    // be read again from the start, or in contiguous pieces
    always_ff @(posedge sysclk) begin
        if (write_trig_reset) begin
            mult_nq <= num_quads;
            offset  <= '0;
        end else if (query_wen || (hub_mem_read && (reg_raddr[8:0] == 9'd0))) begin
            mult_nq <= num_quads;
            offset  <= '0;
        end else if (hub_mem_read && at_boundary) begin
            mult_nq <= mult_nq + num_quads;
            offset  <= offset + quad_offset;
        end
    end

    // the boundary address itself already belongs to the next entry, while the
    // registered offset only catches up one cycle later
    assign raddr_offset = at_boundary ? reg_raddr[8:0] + offset + quad_offset
                                      : reg_raddr[8:0] + offset;

    // look the entry slot up in the board index
    always_comb begin
        slot        = raddr_offset[8:5];
        read_board  = read_index_flat[63 - 4 * slot -: 4];
        first_board = read_index_flat[63:60];
    end

    // the index repeats, so meeting the slot 0 board again after the first
    // boundary means the read has run past the last entry
    assign is_extra = (offset != 9'd0) && (read_board == first_board);

    assign mem_raddr = {read_board, raddr_offset[4:0]};

endmodule

//--- fw_bcast_model.sv
// broadcast transmitter model that turns each write_trig request into a fixed busy period
`timescale 1ns/10ps

module fw_bcast_model
    import hub_pkg::*;
(
    input  logic sysclk,
    input  logic write_trig_reset,
    input  logic write_trig,
    input  logic fw_ext_busy,
    output logic fw_idle
);

    // write_trig from the previous cycle, for edge detection
    logic                trig_d;
    // cycles left in the current transmission
    logic [bc_cnt_w-1:0] busy_cnt;

    always_ff @(posedge sysclk) begin
        if (write_trig_reset) begin
            trig_d   <= 1'b0;
            busy_cnt <= '0;
        end else begin
            trig_d <= write_trig;
            if (write_trig && !trig_d) begin
                // a new request starts a packet of fixed length
                busy_cnt <= bc_cnt_w'(bc_xmit_cycles);
            end else if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
        end
    end

    // outside traffic on the bus also keeps the transmitter from being idle
    assign fw_idle = (busy_cnt == '0) && !fw_ext_busy;

endmodule

//--- hub_top.sv
// hub top level joining the register block, read translator, hub memory and transmit model
`timescale 1ns/10ps

module hub_top (
    input  logic        sysclk,
    input  logic        write_trig_reset,
    input  logic        reg_wen,
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic [15:0] reg_raddr,
    output logic [31:0] reg_rdata,
    input  logic [3:0]  board_id,
    input  logic        fw_ext_busy,
    output logic [15:0] seq_num,
    output logic [15:0] board_mask,
    output logic        updated,
    output logic        write_trig
);

    // memory write side, driven by the register block
    logic        mem_wen;
    logic [8:0]  mem_waddr;
    logic [31:0] mem_wdata;
    // memory read side, addressed through the translator
    logic [8:0]  mem_raddr;
    logic [31:0] mem_rdata;
    logic [3:0]  read_board;
    logic        is_extra;
    logic [63:0] read_index_flat;
    logic        query_wen;
    logic        fw_idle;

    hub_reg hub_reg_inst (
        .sysclk           (sysclk),
        .write_trig_reset (write_trig_reset),
        .reg_wen          (reg_wen),
        .reg_waddr        (reg_waddr),
        .reg_wdata        (reg_wdata),
        .reg_raddr        (reg_raddr),
        .board_id         (board_id),
        .fw_idle          (fw_idle),
        .mem_rdata        (mem_rdata),
        .read_board       (read_board),
        .is_extra         (is_extra),
        .reg_rdata        (reg_rdata),
        .seq_num          (seq_num),
        .board_mask       (board_mask),
        .updated          (updated),
        .write_trig       (write_trig),
        .query_wen        (query_wen),
        .read_index_flat  (read_index_flat),
        .mem_wen          (mem_wen),
        .mem_waddr        (mem_waddr),
        .mem_wdata        (mem_wdata)
    );

    hub_read_xlate hub_read_xlate_inst (
        .sysclk           (sysclk),
        .write_trig_reset (write_trig_reset),
        .reg_raddr        (reg_raddr),
        .query_wen        (query_wen),
        .read_index_flat  (read_index_flat),
        .mem_raddr        (mem_raddr),
        .read_board       (read_board),
        .is_extra         (is_extra)
    );

    hub_mem hub_mem_inst (
        .sysclk (sysclk),
        .wen    (mem_wen),
        .waddr  (mem_waddr),
        .wdata  (mem_wdata),
        .raddr  (mem_raddr),
        .rdata  (mem_rdata)
    );

    fw_bcast_model fw_bcast_model_inst (
        .sysclk           (sysclk),
        .write_trig_reset (write_trig_reset),
        .write_trig       (write_trig),
        .fw_ext_busy      (fw_ext_busy),
        .fw_idle          (fw_idle)
    );

endmodule

//--- hub_assertions.sv
// hub register assertions on broadcast ordering, hub memory writes and the update flag
`timescale 1ns/10ps

module hub_assertions
    import hub_pkg::*;
(
    input logic        sysclk,
    input logic        write_trig_reset,
    input logic [3:0]  board_id,
    input logic [15:0] board_mask,
    input logic        fw_idle,
    input logic        write_trig,
    input logic        query_wen,
    input logic        updated,
    input logic        mem_wen,
    input logic [15:0] reg_waddr,
    input logic [15:0] board_updated
);

    // this board is in use and no board with a lower number is
    logic lowest_board;
    // number of failed assertion checks
    int   fail_cnt;

    assign lowest_board = board_mask[board_id]
                          && ((board_mask & ((16'd1 << board_id) - 16'd1)) == 16'd0);

    // only the lowest board may start while the transmitter is busy
    trig_needs_idle: assert property (@(posedge sysclk) disable iff (write_trig_reset)
        $rose(write_trig) |-> ($past(fw_idle) || $past(lowest_board)))
        else begin
            $error("write_trig rose while the transmitter was busy");
            fail_cnt++;
        end

    // hub memory is only written from hub address space, and the entry write
    // marks its board as updated from the next cycle on
    mem_write_in_hub: assert property (@(posedge sysclk) disable iff (write_trig_reset)
        mem_wen |-> (reg_waddr[15:12] == addr_hub) ##1 board_updated[$past(reg_waddr[8:5])])
        else begin
            $error("hub memory write outside hub space or its board not marked updated");
            fail_cnt++;
        end

    // a query clears every update bit
    query_clears_updated: assert property (@(posedge sysclk) disable iff (write_trig_reset)
        query_wen |=> !updated)
        else begin
            $error("updated still high after a query");
            fail_cnt++;
        end

endmodule

//--- hub_tb.sv
// hub testbench that replays the pattern file on the register bus and checks reads and outputs
`timescale 1ns/10ps

module hub_tb;

    localparam pattern_file = "hub_patterns.txt";

    logic        sysclk;
    logic        write_trig_reset;
    logic        reg_wen;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic [15:0] reg_raddr;
    logic [31:0] reg_rdata;
    logic [3:0]  board_id;
    logic        fw_ext_busy;
    logic [15:0] seq_num;
    logic [15:0] board_mask;
    logic        updated;
    logic        write_trig;

    // one entry per operation line of the pattern file
    byte         op_code [$];
    logic [31:0] op_a [$];
    logic [31:0] op_b [$];
    logic [31:0] op_c [$];
    int          cycle_limit;
    int          cycle_cnt;
    // last nonzero mask sent with a query, the index check is built from it
    logic [15:0] query_mask;

    // ports in declaration order
    hub_top hub_top_inst (
        sysclk, write_trig_reset, reg_wen, reg_waddr, reg_wdata, reg_raddr, reg_rdata,
        board_id, fw_ext_busy, seq_num, board_mask, updated, write_trig
    );

    bind hub_reg hub_assertions hub_assertions_inst (
        .sysclk           (sysclk),
        .write_trig_reset (write_trig_reset),
        .board_id         (board_id),
        .board_mask       (board_mask),
        .fw_idle          (fw_idle),
        .write_trig       (write_trig),
        .query_wen        (query_wen),
        .updated          (updated),
        .mem_wen          (mem_wen),
        .reg_waddr        (reg_waddr),
        .board_updated    (board_updated)
    );

    always #50 sysclk = ~sysclk;

    // the run may take the waits of the pattern file plus a fixed margin
    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: no end of the run within %0d cycles", cycle_limit);
            $display("Test failed");
            $fatal(1, "run timed out");
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Test failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // index slots hold the boards in use in ascending order, repeated until all 16 are full
    function automatic logic [63:0] expected_index(input logic [15:0] mask);
        logic [63:0] idx;
        int          slot;
        int          b;
        idx  = '0;
        slot = 0;
        b    = 0;
        while ((mask != 16'd0) && (slot < 16)) begin
            if (mask[b]) begin
                idx[63 - 4 * slot -: 4] = 4'(b);
                slot++;
            end
            b = (b + 1) % 16;
        end
        return idx;
    endfunction

    task automatic load_patterns();
        int               fd;
        int               n;
        byte              op;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        logic [8*256-1:0] rest;
        fd = $fopen(pattern_file, "r");
        if (fd == 0) begin
            $display("could not open the pattern file %s", pattern_file);
            $display("Test failed");
            $fatal(1, "no stimulus");
        end
        cycle_limit = 2000;
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", op);
            if (n != 1) begin
                break;
            end
            a = '0;
            b = '0;
            c = '0;
            case (op)
                "#":           n = $fgets(rest, fd);
                "W":           n = $fscanf(fd, "%h %h", a, b);
                "R":           n = $fscanf(fd, "%h %h %h", a, b, c);
                "B", "X":      n = $fscanf(fd, "%h", a);
                "N":           n = $fscanf(fd, "%d", a);
                "T", "U":      n = $fscanf(fd, "%h %d", a, b);
                "I":           n = 0;
                default: begin
                    $display("unknown operation %c in the pattern file", op);
                    $display("Test failed");
                    $fatal(1, "bad pattern file");
                end
            endcase
            if (op != "#") begin
                op_code.push_back(op);
                op_a.push_back(a);
                op_b.push_back(b);
                op_c.push_back(c);
                // every cycle that the file asks to wait counts toward the limit
                if (op == "N") cycle_limit += a;
                if (op == "T" || op == "U") cycle_limit += b;
            end
        end
        $fclose(fd);
    endtask

    // a write is seen by the DUT at the edge after it is driven
    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge sysclk);
        reg_wen   <= 1'b1;
        reg_waddr <= addr;
        reg_wdata <= data;
        @(posedge sysclk);
        reg_wen <= 1'b0;
        // a query with a zero mask keeps the old mask
        if ((addr == 16'h1800) && (data[15:0] != 16'd0)) begin
            query_mask = data[15:0];
        end
    endtask

    // the address is held for two cycles so registered memory data has arrived
    task automatic bus_read(input logic [15:0] addr, input logic [31:0] exp,
                            input logic [31:0] care);
        @(posedge sysclk);
        reg_raddr <= addr;
        repeat (2) @(posedge sysclk);
        check_val($sformatf("reg_rdata[%04h]", addr), reg_rdata & care, exp & care);
        // the query register also drives the sequence and mask outputs directly
        if (addr == 16'h1800) begin
            check_val("seq_num", 32'(seq_num & care[31:16]), 32'(exp[31:16] & care[31:16]));
            check_val("board_mask", 32'(board_mask & care[15:0]), 32'(exp[15:0] & care[15:0]));
        end
    endtask

    function automatic logic probe(input byte op);
        return (op == "T") ? write_trig : updated;
    endfunction

    // wait up to max_cycles for the output to reach the level, zero checks it right away
    task automatic wait_level(input byte op, input logic lvl, input int max_cycles);
        int i;
        i = 0;
        while ((probe(op) !== lvl) && (i < max_cycles)) begin
            @(posedge sysclk);
            i++;
        end
        check_val((op == "T") ? "write_trig" : "updated", 32'(probe(op)), 32'(lvl));
    endtask

    task automatic check_index();
        logic [63:0] idx;
        idx = expected_index(query_mask);
        bus_read(16'h1801, idx[63:32], 32'hffff_ffff);
        bus_read(16'h1802, idx[31:0], 32'hffff_ffff);
    endtask

    initial begin
        sysclk           = 1'b0;
        write_trig_reset = 1'b1;
        reg_wen          = 1'b0;
        reg_waddr        = '0;
        reg_wdata        = '0;
        reg_raddr        = '0;
        board_id         = '0;
        fw_ext_busy      = 1'b0;
        cycle_cnt        = 0;
        query_mask       = '0;
        load_patterns();
        repeat (4) @(posedge sysclk);
        write_trig_reset <= 1'b0;
        for (int i = 0; i < op_code.size(); i++) begin
            case (op_code[i])
                "W":      bus_write(op_a[i][15:0], op_b[i]);
                "R":      bus_read(op_a[i][15:0], op_b[i], op_c[i]);
                "B": begin
                    @(posedge sysclk);
                    board_id <= op_a[i][3:0];
                end
                "X": begin
                    @(posedge sysclk);
                    fw_ext_busy <= op_a[i][0];
                end
                "N":      repeat (op_a[i]) @(posedge sysclk);
                "T", "U": wait_level(op_code[i], op_a[i][0], int'(op_b[i]));
                default:  check_index();
            endcase
        end
        repeat (2) @(posedge sysclk);
        // the bound assertions count their failures during the run
        if (hub_top_inst.hub_reg_inst.hub_assertions_inst.fail_cnt == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "assertions in hub_reg failed during the run");
        end
    end

endmodule

//--- hub_patterns.txt
# W addr data | R addr expected care_mask | B board_id | X ext_busy | I index check, in hex
# N cycles in decimal | T write_trig or U updated: level in hex, then max wait cycles in decimal
W 1800 000100a1
N 220
T 0 0
T 1 40
R 1800 000100a1 ffffffff
I
B 5
W 1800 00020000
R 1800 000200a1 ffffffff
R 1803 00050001 ffffffff
T 0 0
X 1
N 200
T 0 0
W 1000 a0a01234
W 1001 00000011
W 101c 0000001c
N 20
T 0 0
U 0 0
X 0
T 1 10
W 10e0 c0c05678
W 10e1 00000071
W 10fc 0000007c
U 0 0
R 1000 a0a08000 ffffc000
R 1001 00000011 ffffffff
R 101c 0000001c ffffffff
R 101d 00000000 0000c000
R 103a c0c08000 ffffc000
R 103b 00000071 ffffffff
R 1056 0000007c ffffffff
R 1057 00000000 c000c000
W 10a0 b0b00000
U 1 5

//--- tb.f
hub_pkg.sv
hub_mem.sv
hub_reg.sv
hub_read_xlate.sv
fw_bcast_model.sv
hub_top.sv
hub_assertions.sv
hub_tb.sv

//--- Bender.yml
package:
  name: hub

sources:
  - files:
      - hub_pkg.sv
      - hub_mem.sv
      - hub_reg.sv
      - hub_read_xlate.sv
      - fw_bcast_model.sv
      - hub_top.sv
  - target: test
    files:
      - hub_assertions.sv
      - hub_tb.sv
